/* common/cmd_if.sv */
`default_nettype none

// One decoded command, four-phase req/ack
interface cmd_if;

	logic               req;
	logic               ack;
	ctrl_pkg::cmd_t     cmd;
	ctrl_pkg::cmd_op_e  op;

	modport decoder (
		output req,
		output cmd,
		output op,
		input  ack
	);

	modport executor (
		input  req,
		input  cmd,
		input  op,
		output ack
	);

endinterface

`default_nettype wire

/* common/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

	// Design version reported by the 'v' command
	localparam logic [7:0] version_major = 8'h00;
	localparam logic [7:0] version_minor = 8'h04;

	// Response status bytes
	localparam logic [7:0] status_ack = 8'h06;
	localparam logic [7:0] status_nak = 8'h15;

	localparam logic [7:0]  i2c_speed_reset = 8'd99;
	localparam logic [15:0] i2c_addr_reset  = 16'hffff;

	localparam int gpio_width      = 24;
	localparam int max_payload     = 4;
	localparam int max_value_bytes = 3;
	localparam int pcount_w        = $clog2(max_payload + 1);
	localparam int vcount_w        = $clog2(max_value_bytes + 1);

	// Command letters and field selectors (ASCII)
	localparam logic [7:0] letter_version = 8'h76;
	localparam logic [1:0] letter_high    = 2'b01;
	localparam logic [4:0] code_i2c       = 5'h09;
	localparam logic [4:0] code_gpio      = 5'h07;
	localparam logic [7:0] field_speed    = 8'h63;
	localparam logic [7:0] field_addr     = 8'h61;
	localparam logic [7:0] field_level    = 8'h6c;
	localparam logic [7:0] field_dir      = 8'h64;

	// Lower case letters carry bit 5, which marks a set
	typedef struct packed {
		logic [1:0] high;
		logic       set;
		logic [4:0] code;
	} cmd_fields_t;

	typedef union packed {
		logic [7:0]  raw;
		cmd_fields_t fields;
	} cmd_byte_u;

	typedef enum logic [1:0] {op_version, op_i2c, op_gpio, op_bad} cmd_op_e;

	typedef logic [max_payload-1:0][7:0] payload_t;

	typedef struct packed {
		cmd_byte_u             cmd;
		logic [7:0]            eid;
		payload_t              payload;
		logic [pcount_w-1:0]   count;
	} cmd_t;

	// Value is left aligned, the first byte sent sits in the top slot
	typedef struct packed {
		logic [7:0]                      status;
		logic [7:0]                      eid;
		logic [max_value_bytes-1:0][7:0] value;
		logic [vcount_w-1:0]             count;
	} res_t;

endpackage

`default_nettype wire

/* common/res_if.sv */
`default_nettype none

// One response descriptor, four-phase req/ack plus frame done pulse
interface res_if;

	logic            req;
	logic            ack;
	logic            sent;
	ctrl_pkg::res_t  res;

	modport producer (
		output req,
		output res,
		input  ack,
		input  sent
	);

	modport consumer (
		input  req,
		input  res,
		output ack,
		output sent
	);

endinterface

`default_nettype wire

/* filelist.f */
common/ctrl_pkg.sv
common/cmd_if.sv
common/res_if.sv
rtl/cmd_decode.sv
rtl/cmd_execute.sv
rtl/result_serializer.sv
rtl/basics_ctrl_top.sv
verification/basics_ctrl_properties.sv
verification/basics_ctrl_tb.sv

/* rtl/basics_ctrl_top.sv */
`default_nettype none

module basics_ctrl_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [7:0]                      in_data,
	input  logic                            in_valid,
	input  logic                            in_frame,
	input  logic                            resp_ack,
	output logic [7:0]                      resp_data,
	output logic                            resp_last,
	output logic                            resp_req,
	output logic [7:0]                      i2c_speed,
	output logic [15:0]                     i2c_addr,
	output logic [ctrl_pkg::gpio_width-1:0] gpio_level,
	output logic [ctrl_pkg::gpio_width-1:0] gpio_direction,
	input  logic [ctrl_pkg::gpio_width-1:0] gpio_read
);

	cmd_if cmd_bus ();
	res_if res_bus ();

	// Frame parser
	cmd_decode u_decode (
		.clk      (clk),
		.rst      (rst),
		.in_data  (in_data),
		.in_valid (in_valid),
		.in_frame (in_frame),
		.cmd      (cmd_bus.decoder)
	);

	// Settings and response building
	cmd_execute u_execute (
		.clk            (clk),
		.rst            (rst),
		.gpio_read      (gpio_read),
		.cmd            (cmd_bus.executor),
		.res            (res_bus.producer),
		.i2c_speed      (i2c_speed),
		.i2c_addr       (i2c_addr),
		.gpio_level     (gpio_level),
		.gpio_direction (gpio_direction)
	);

	// Byte output toward the host
	result_serializer u_serializer (
		.clk       (clk),
		.rst       (rst),
		.resp_ack  (resp_ack),
		.res       (res_bus.consumer),
		.resp_data (resp_data),
		.resp_last (resp_last),
		.resp_req  (resp_req)
	);

endmodule

`default_nettype wire

/* rtl/cmd_decode.sv */
`default_nettype none

module cmd_decode (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] in_data,
	input  logic       in_valid,
	input  logic       in_frame,
	cmd_if.decoder     cmd
);

	logic              frame_q;
	logic              dropping;
	logic [1:0]        pos;
	logic              busy;
	logic              frame_start;
	logic              frame_end;
	logic              take;
	logic              issue;
	ctrl_pkg::cmd_op_e op_next;

	// Held command not yet released by the executor
	assign busy = cmd.req | cmd.ack;

	assign frame_start = in_frame & ~frame_q;
	assign frame_end   = ~in_frame & frame_q;

	// A frame opening while busy is ignored up to its end
	assign take  = in_frame & in_valid & ~dropping & ~(frame_start & busy);
	assign issue = frame_end & ~dropping & (pos != 2'd0);

	always_comb begin
		if (cmd.cmd.cmd.raw == ctrl_pkg::letter_version)
			op_next = ctrl_pkg::op_version;
		else if (cmd.cmd.cmd.fields.high == ctrl_pkg::letter_high &&
				cmd.cmd.cmd.fields.code == ctrl_pkg::code_i2c)
			op_next = ctrl_pkg::op_i2c;
		else if (cmd.cmd.cmd.fields.high == ctrl_pkg::letter_high &&
				cmd.cmd.cmd.fields.code == ctrl_pkg::code_gpio)
			op_next = ctrl_pkg::op_gpio;
		else
			op_next = ctrl_pkg::op_bad;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_q  <= 1'b0;
			dropping <= 1'b0;
			pos      <= 2'd0;
			cmd.req  <= 1'b0;
		end else begin
			frame_q <= in_frame;

			if (frame_start && busy)
				dropping <= 1'b1;
			else if (!in_frame)
				dropping <= 1'b0;

			// Position stops at the payload slot
			if (!in_frame)
				pos <= 2'd0;
			else if (take && pos != 2'd3)
				pos <= pos + 2'd1;

			if (issue)
				cmd.req <= 1'b1;
			else if (cmd.ack)
				cmd.req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			case (pos)
				2'd0: begin
					cmd.cmd.cmd.raw <= in_data;
					cmd.cmd.count   <= '0;
				end
				2'd1: cmd.cmd.eid <= in_data;
				2'd3: begin
					if (cmd.cmd.count < ctrl_pkg::max_payload) begin
						cmd.cmd.payload[cmd.cmd.count] <= in_data;
						cmd.cmd.count <= cmd.cmd.count + 1'b1;
					end
				end
				// Length byte carries nothing we use
				default: ;
			endcase
		end
		if (issue)
			cmd.op <= op_next;
	end

endmodule

`default_nettype wire

/* rtl/cmd_execute.sv */
`default_nettype none

module cmd_execute (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [ctrl_pkg::gpio_width-1:0] gpio_read,
	cmd_if.executor                         cmd,
	res_if.producer                         res,
	output logic [7:0]                      i2c_speed,
	output logic [15:0]                     i2c_addr,
	output logic [ctrl_pkg::gpio_width-1:0] gpio_level,
	output logic [ctrl_pkg::gpio_width-1:0] gpio_direction
);

	logic                            accept;
	logic                            desc_ready;
	logic                            is_set;
	logic [7:0]                      field;
	logic [ctrl_pkg::pcount_w-1:0]   nvals;
	logic [ctrl_pkg::gpio_width-1:0] set_word;
	logic                            wr_speed;
	logic                            wr_addr;
	logic                            wr_level;
	logic                            wr_dir;
	ctrl_pkg::res_t                  desc;
	logic [ctrl_pkg::gpio_width-1:0] stage;
	logic                            stage_dir;
	logic                            stage_valid;
	logic                            stage_armed;

	// Wait for the serializer to take the last descriptor and for any GPIO commit
	assign accept = cmd.req & ~cmd.ack & ~res.req & ~res.ack & ~stage_valid;

	assign is_set   = cmd.cmd.cmd.fields.set;
	assign field    = (cmd.cmd.count != '0) ? cmd.cmd.payload[0] : 8'h00;
	assign nvals    = cmd.cmd.count - 1'b1;
	assign set_word = {cmd.cmd.payload[1], cmd.cmd.payload[2], cmd.cmd.payload[3]};

	always_comb begin
		desc        = '0;
		desc.status = ctrl_pkg::status_nak;
		desc.eid    = cmd.cmd.eid;
		wr_speed    = 1'b0;
		wr_addr     = 1'b0;
		wr_level    = 1'b0;
		wr_dir      = 1'b0;
		case (cmd.op)
			ctrl_pkg::op_version: begin
				if (cmd.cmd.count >= 2 &&
						cmd.cmd.payload[0] == ctrl_pkg::version_major &&
						cmd.cmd.payload[1] == ctrl_pkg::version_minor) begin
					desc.status = ctrl_pkg::status_ack;
				end else begin
					desc.value = {ctrl_pkg::version_major, ctrl_pkg::version_minor, 8'h00};
					desc.count = 2'd2;
				end
			end
			ctrl_pkg::op_i2c: begin
				if (field == ctrl_pkg::field_speed && !is_set) begin
					desc.status = ctrl_pkg::status_ack;
					desc.value  = {i2c_speed, 16'h0000};
					desc.count  = 2'd1;
				end else if (field == ctrl_pkg::field_speed && nvals == 1) begin
					desc.status = ctrl_pkg::status_ack;
					wr_speed    = 1'b1;
				end else if (field == ctrl_pkg::field_addr && !is_set) begin
					desc.status = ctrl_pkg::status_ack;
					desc.value  = {i2c_addr, 8'h00};
					desc.count  = 2'd2;
				end else if (field == ctrl_pkg::field_addr && nvals == 2) begin
					desc.status = ctrl_pkg::status_ack;
					wr_addr     = 1'b1;
				end
			end
			ctrl_pkg::op_gpio: begin
				if (field == ctrl_pkg::field_level && !is_set) begin
					desc.status = ctrl_pkg::status_ack;
					desc.value  = gpio_read;
					desc.count  = 2'd3;
				end else if (field == ctrl_pkg::field_level && nvals == 3) begin
					desc.status = ctrl_pkg::status_ack;
					wr_level    = 1'b1;
				end else if (field == ctrl_pkg::field_dir && !is_set) begin
					desc.status = ctrl_pkg::status_ack;
					desc.value  = gpio_direction;
					desc.count  = 2'd3;
				end else if (field == ctrl_pkg::field_dir && nvals == 3) begin
					desc.status = ctrl_pkg::status_ack;
					wr_dir      = 1'b1;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cmd.ack        <= 1'b0;
			res.req        <= 1'b0;
			desc_ready     <= 1'b0;
			stage_valid    <= 1'b0;
			stage_armed    <= 1'b0;
			i2c_speed      <= ctrl_pkg::i2c_speed_reset;
			i2c_addr       <= ctrl_pkg::i2c_addr_reset;
			gpio_level     <= '0;
			gpio_direction <= '0;
		end else begin
			desc_ready <= accept;

			if (accept)
				cmd.ack <= 1'b1;
			else if (!cmd.req)
				cmd.ack <= 1'b0;

			if (desc_ready)
				res.req <= 1'b1;
			else if (res.ack)
				res.req <= 1'b0;

			// I2C settings apply as soon as the response is built
			if (accept && wr_speed)
				i2c_speed <= cmd.cmd.payload[1];
			if (accept && wr_addr)
				i2c_addr <= {cmd.cmd.payload[1], cmd.cmd.payload[2]};

			// GPIO commit waits for the end of its own response frame
			if (accept && (wr_level || wr_dir))
				stage_valid <= 1'b1;
			else if (res.sent && stage_armed)
				stage_valid <= 1'b0;

			if (stage_valid && res.req && res.ack)
				stage_armed <= 1'b1;
			else if (res.sent)
				stage_armed <= 1'b0;

			if (res.sent && stage_armed) begin
				if (stage_dir)
					gpio_direction <= stage;
				else
					gpio_level <= stage;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			res.res <= desc;
			if (wr_level || wr_dir) begin
				stage     <= set_word;
				stage_dir <= wr_dir;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/result_serializer.sv */
`default_nettype none

module result_serializer (
	input  logic       clk,
	input  logic       rst,
	input  logic       resp_ack,
	res_if.consumer    res,
	output logic [7:0] resp_data,
	output logic       resp_last,
	output logic       resp_req
);

	ctrl_pkg::res_t desc_q;
	logic [2:0]     idx;
	logic           busy;
	logic           start;
	logic           load;
	logic           advance;

	assign load = ~busy & res.req & ~res.ack;

	// Host has dropped its ack for the current byte
	assign advance = busy & ~start & ~resp_req & ~resp_ack;

	assign resp_last = (idx == ({1'b0, desc_q.count} + 3'd1));

	always_comb begin
		case (idx)
			3'd0: resp_data = desc_q.status;
			3'd1: resp_data = desc_q.eid;
			default: resp_data = desc_q.value[ctrl_pkg::max_value_bytes-1];
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			start    <= 1'b0;
			idx      <= 3'd0;
			resp_req <= 1'b0;
			res.ack  <= 1'b0;
			res.sent <= 1'b0;
		end else begin
			start    <= load;
			res.sent <= 1'b0;

			if (load)
				res.ack <= 1'b1;
			else if (!res.req)
				res.ack <= 1'b0;

			if (load) begin
				busy <= 1'b1;
				idx  <= 3'd0;
			end

			if (start)
				resp_req <= 1'b1;
			if (resp_req && resp_ack)
				resp_req <= 1'b0;

			if (advance) begin
				if (resp_last) begin
					busy     <= 1'b0;
					res.sent <= 1'b1;
				end else begin
					idx      <= idx + 3'd1;
					resp_req <= 1'b1;
				end
			end
		end
	end

	// Value bytes leave from the top slot
	always_ff @(posedge clk) begin
		if (load)
			desc_q <= res.res;
		else if (advance && !resp_last && idx >= 3'd2)
			desc_q.value <= {desc_q.value[ctrl_pkg::max_value_bytes-2:0], 8'h00};
	end

endmodule

`default_nettype wire

/* verification/basics_ctrl_properties.sv */
`default_nettype none

module basics_ctrl_properties (
	input logic       clk,
	input logic       rst,
	input logic       resp_req,
	input logic       resp_ack,
	input logic [7:0] resp_data,
	input logic       resp_last
);

	// Failure tally, read back at the end of the run
	int failures = 0;

	// Byte and last flag hold for the whole request
	hold_data: assert property (@(posedge clk) disable iff (rst)
		resp_req |=> !resp_req || ($stable(resp_data) && $stable(resp_last)))
	else begin
		$error("resp_data or resp_last changed while resp_req was high");
		failures++;
	end

	// Request stays up until the host answers
	no_early_drop: assert property (@(posedge clk) disable iff (rst)
		resp_req && !resp_ack |=> resp_req)
	else begin
		$error("resp_req fell before resp_ack rose");
		failures++;
	end

	reset_idle: assert property (@(posedge clk) rst |=> !resp_req)
	else begin
		$error("resp_req was high in the cycle after reset");
		failures++;
	end

endmodule

bind result_serializer basics_ctrl_properties u_props (
	.clk       (clk),
	.rst       (rst),
	.resp_req  (resp_req),
	.resp_ack  (resp_ack),
	.resp_data (resp_data),
	.resp_last (resp_last)
);

`default_nettype wire

/* verification/basics_ctrl_tb.sv */
`default_nettype none

module basics_ctrl_tb;

	localparam int         period         = 4;
	// 22 frames at up to about 60 cycles each plus reset, with margin
	localparam int         timeout_cycles = 2000;
	localparam int         max_cmds       = 16;
	localparam logic [7:0] ack_byte       = 8'h06;
	localparam logic [7:0] nak_byte       = 8'h15;

	logic        clk;
	logic        rst;
	logic [7:0]  in_data;
	logic        in_valid;
	logic        in_frame;
	logic        resp_ack;
	logic [7:0]  resp_data;
	logic        resp_last;
	logic        resp_req;
	logic [7:0]  i2c_speed;
	logic [15:0] i2c_addr;
	logic [23:0] gpio_level;
	logic [23:0] gpio_direction;
	logic [23:0] gpio_read;

	// Command table, replayed by the slow host test
	logic [7:0] tx_mem [0:max_cmds-1][0:6];
	int         tx_len [0:max_cmds-1];
	logic [7:0] ex_mem [0:max_cmds-1][0:4];
	int         ex_len [0:max_cmds-1];
	int         n_cmds;

	logic [7:0]  rx_bytes [$];
	logic [23:0] dir_val;
	logic [23:0] lvl_val;
	int          seed;
	int          errors;
	int          checks;
	int          cycles;
	int          frames_done;
	int          prop_fails;

	basics_ctrl_top dut (
		.clk            (clk),
		.rst            (rst),
		.in_data        (in_data),
		.in_valid       (in_valid),
		.in_frame       (in_frame),
		.resp_ack       (resp_ack),
		.resp_data      (resp_data),
		.resp_last      (resp_last),
		.resp_req       (resp_req),
		.i2c_speed      (i2c_speed),
		.i2c_addr       (i2c_addr),
		.gpio_level     (gpio_level),
		.gpio_direction (gpio_direction),
		.gpio_read      (gpio_read)
	);

	always #(period / 2) clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("Timeout after %0d cycles, the response stream stopped", cycles);
			$display("checks=%0d errors=%0d", checks, errors);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("ERR %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
		end
	endtask

	// Payload and value carry their first byte in the top position
	task automatic add_cmd(input logic [7:0] letter, input logic [7:0] eid, input int np,
			input logic [31:0] payload, input logic [7:0] status, input int nv,
			input logic [23:0] value);
		int i;
		tx_mem[n_cmds][0] = letter;
		tx_mem[n_cmds][1] = eid;
		tx_mem[n_cmds][2] = 8'(np);
		for (i = 0; i < np; i++)
			tx_mem[n_cmds][3 + i] = payload[31 - 8 * i -: 8];
		tx_len[n_cmds] = 3 + np;
		ex_mem[n_cmds][0] = status;
		ex_mem[n_cmds][1] = eid;
		for (i = 0; i < nv; i++)
			ex_mem[n_cmds][2 + i] = value[23 - 8 * i -: 8];
		ex_len[n_cmds] = 2 + nv;
		n_cmds++;
	endtask

	task automatic send_frame(input int k);
		int i;
		for (i = 0; i < tx_len[k]; i++) begin
			@(posedge clk);
			in_frame <= 1'b1;
			in_valid <= 1'b1;
			in_data  <= tx_mem[k][i];
		end
		@(posedge clk);
		in_frame <= 1'b0;
		in_valid <= 1'b0;
		in_data  <= 8'h00;
	endtask

	// Host side of the byte handshake, random ack delay
	task automatic recv_frame;
		int   delay;
		logic done;
		rx_bytes.delete();
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			while (!resp_req)
				@(negedge clk);
			rx_bytes.push_back(resp_data);
			done = resp_last;
			delay = $unsigned($random(seed)) % 4;
			repeat (delay) @(posedge clk);
			@(posedge clk);
			resp_ack <= 1'b1;
			@(negedge clk);
			while (resp_req)
				@(negedge clk);
			@(posedge clk);
			resp_ack <= 1'b0;
		end
	endtask

	task automatic compare_frame(input int k);
		int i;
		checks++;
		assert (rx_bytes.size() == ex_len[k]) else begin
			errors++;
			$display("ERR %0t frame_len[%0d] expected %0d actual %0d",
				$time, k, ex_len[k], rx_bytes.size());
		end
		if (rx_bytes.size() == ex_len[k]) begin
			for (i = 0; i < ex_len[k]; i++)
				check_value($sformatf("resp_data[%0d][%0d]", k, i), rx_bytes[i], ex_mem[k][i]);
		end
	endtask

	task automatic exchange(input logic [7:0] letter, input logic [7:0] eid, input int np,
			input logic [31:0] payload, input logic [7:0] status, input int nv,
			input logic [23:0] value);
		add_cmd(letter, eid, np, payload, status, nv, value);
		send_frame(n_cmds - 1);
		recv_frame();
		compare_frame(n_cmds - 1);
	endtask

	task automatic reset_values;
		@(negedge clk);
		check_value("i2c_speed", i2c_speed, 99);
		check_value("i2c_addr", i2c_addr, 16'hffff);
		check_value("gpio_level", gpio_level, 0);
		check_value("gpio_direction", gpio_direction, 0);
		check_value("resp_req", resp_req, 0);
	endtask

	task automatic version_check;
		exchange("v", 8'h11, 2, 32'h0004_0000, ack_byte, 0, 24'h0);
		// Mismatch answers with the design version 00 04
		exchange("v", 8'h12, 2, 32'h0100_0000, nak_byte, 2, 24'h0004_00);
	endtask

	task automatic i2c_settings;
		exchange("i", 8'h21, 3, {"a", 24'h1234_00}, ack_byte, 0, 24'h0);
		exchange("I", 8'h22, 1, {"a", 24'h0}, ack_byte, 2, 24'h1234_00);
		@(negedge clk);
		check_value("i2c_addr", i2c_addr, 16'h1234);
		// Speed is one byte wide, two bytes is a bad set
		exchange("i", 8'h23, 3, {"c", 24'h5566_00}, nak_byte, 0, 24'h0);
		@(negedge clk);
		check_value("i2c_speed", i2c_speed, 99);
	endtask

	task automatic gpio_settings;
		lvl_val = $random(seed);
		exchange("g", 8'h31, 4, {"d", dir_val}, ack_byte, 0, 24'h0);
		@(negedge clk);
		check_value("gpio_direction", gpio_direction, 0);
		repeat (3) @(negedge clk);
		check_value("gpio_direction", gpio_direction, dir_val);
		exchange("G", 8'h32, 1, {"d", 24'h0}, ack_byte, 3, dir_val);
		exchange("G", 8'h33, 1, {"l", 24'h0}, ack_byte, 3, gpio_read);
		// Level set commits the same way as direction
		exchange("g", 8'h34, 4, {"l", lvl_val}, ack_byte, 0, 24'h0);
		repeat (4) @(negedge clk);
		check_value("gpio_level", gpio_level, lvl_val);
	endtask

	task automatic unknown_commands;
		exchange("x", 8'h41, 0, 32'h0, nak_byte, 0, 24'h0);
		exchange("I", 8'h42, 1, {"z", 24'h0}, nak_byte, 0, 24'h0);
	endtask

	// Replay every frame so far with up to two commands in flight
	task automatic slow_host_replay;
		int n;
		int k;
		int j;
		n = n_cmds;
		frames_done = 0;
		fork
			begin
				for (k = 0; k < n; k++) begin
					wait (frames_done >= k - 1);
					repeat (8) @(posedge clk);
					send_frame(k);
				end
			end
			begin
				for (j = 0; j < n; j++) begin
					recv_frame();
					compare_frame(j);
					frames_done++;
				end
			end
		join
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		in_data = 8'h00;
		in_valid = 1'b0;
		in_frame = 1'b0;
		resp_ack = 1'b0;
		gpio_read = 24'h0;
		seed = 72761;
		errors = 0;
		checks = 0;
		cycles = 0;
		n_cmds = 0;
		frames_done = 0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		reset_values();
		dir_val = $random(seed);
		@(posedge clk);
		gpio_read <= $random(seed);
		version_check();
		i2c_settings();
		gpio_settings();
		unknown_commands();
		slow_host_replay();
		repeat (4) @(posedge clk);
		prop_fails = dut.u_serializer.u_props.failures;
		$display("checks=%0d errors=%0d assertion_failures=%0d", checks, errors, prop_fails);
		if (errors == 0 && prop_fails == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
